// ==== hw/dram_fifo_pkg.sv ====
// stream FIFO shared definitions
// widths, word types, settings register offsets and the output buffer state

package dram_fifo_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int DATA_W     = 64;                 // stream data
    localparam int RB_W       = 32;                 // settings data and readback
    localparam int SET_ADDR_W = 8;                  // settings address

    // --------------------------------------------------
    // word types
    // --------------------------------------------------
    typedef logic [DATA_W-1:0]     tdata_t;         // stream data word
    typedef logic [DATA_W:0]       mem_word_t;      // last flag on top, data below
    typedef logic [RB_W-1:0]       set_data_t;      // settings write data, readback
    typedef logic [SET_ADDR_W-1:0] set_addr_t;      // settings address

    // --------------------------------------------------
    // settings register map, offsets from SR_BASE
    // --------------------------------------------------
    localparam set_addr_t REG_BASE_OFS = 8'd0;      // window base
    localparam set_addr_t REG_MASK_OFS = 8'd1;      // window mask

    // output buffer fill level
    typedef enum logic [1:0] {
        EMPTY,                                      // nothing held
        ONE,                                        // oldest word only
        TWO                                         // both entries used
    } out_state_t;

endpackage

// ==== hw/fifo_settings_regs.sv ====
// settings bus decode for the FIFO window
// holds base and mask, pulses a FIFO clear on every write to either

`timescale 1ns/1ps

module fifo_settings_regs #(
    parameter int                ADDR_W       = 10,
    parameter int                SR_BASE      = 0,
    parameter logic [ADDR_W-1:0] DEFAULT_BASE = '0,
    parameter logic [ADDR_W-1:0] DEFAULT_MASK = {ADDR_W{1'b1}} << 8
) (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_rst,
    input  logic                      i_set_stb,
    input  dram_fifo_pkg::set_addr_t  i_set_addr,
    input  dram_fifo_pkg::set_data_t  i_set_data,
    output logic [ADDR_W-1:0]         o_base,
    output logic [ADDR_W-1:0]         o_mask,
    output logic                      o_clear
);

    // absolute register addresses on the settings bus
    localparam dram_fifo_pkg::set_addr_t BASE_ADDR =
        dram_fifo_pkg::set_addr_t'(SR_BASE) + dram_fifo_pkg::REG_BASE_OFS;
    localparam dram_fifo_pkg::set_addr_t MASK_ADDR =
        dram_fifo_pkg::set_addr_t'(SR_BASE) + dram_fifo_pkg::REG_MASK_OFS;

    logic hit_base;                                     // strobe on base reg
    logic hit_mask;                                     // strobe on mask reg

    assign hit_base = i_set_stb && (i_set_addr == BASE_ADDR);
    assign hit_mask = i_set_stb && (i_set_addr == MASK_ADDR);

    // --------------------------------------------------
    // registers, all update one cycle after the strobe
    // --------------------------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_rst) begin
            o_base  <= DEFAULT_BASE;
            o_mask  <= DEFAULT_MASK;
            o_clear <= 1'b0;
        end else begin
            if (hit_base) begin
                o_base <= i_set_data[ADDR_W-1:0];       // upper bits ignored
            end
            if (hit_mask) begin
                o_mask <= i_set_data[ADDR_W-1:0];
            end
            o_clear <= hit_base || hit_mask;            // lines up with new window
        end
    end

endmodule

// ==== hw/fifo_ptr_ctrl.sv ====
// FIFO pointer control inside the memory window
// write/read offsets, fill count, input ready and memory read issue

`timescale 1ns/1ps

module fifo_ptr_ctrl #(
    parameter int ADDR_W = 10
) (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_rst,
    input  logic                      i_clear,
    input  logic [ADDR_W-1:0]         i_base,
    input  logic [ADDR_W-1:0]         i_mask,
    input  dram_fifo_pkg::tdata_t     i_tdata,
    input  logic                      i_tlast,
    input  logic                      i_tvalid,
    output logic                      o_tready,
    input  logic                      i_room,
    output logic                      o_wr_en,
    output logic [ADDR_W-1:0]         o_wr_addr,
    output dram_fifo_pkg::mem_word_t  o_wr_word,
    output logic                      o_rd_en,
    output logic [ADDR_W-1:0]         o_rd_addr,
    output dram_fifo_pkg::set_data_t  o_fill
);

    typedef logic [ADDR_W-1:0] addr_t;                  // offset or memory address
    typedef logic [ADDR_W:0]   count_t;                 // 0 .. window size

    addr_t  wr_ofs_q;                                   // next offset to write
    addr_t  rd_ofs_q;                                   // next offset to read
    addr_t  ofs_last;                                   // highest offset in window
    count_t win_size;
    count_t fill_q;                                     // words held in memory
    count_t fill_d;
    logic   ready_q;                                    // fill below window size

    // offset step with wrap at the window end
    function automatic addr_t step_ofs(input addr_t ofs, input addr_t last);
        return (ofs == last) ? '0 : ofs + addr_t'(1);
    endfunction

    // --------------------------------------------------
    // window and physical addresses
    // --------------------------------------------------
    assign ofs_last  = ~i_mask;                         // mask zeros select offset bits
    assign win_size  = {1'b0, ofs_last} + count_t'(1);

    assign o_wr_addr = (i_base & i_mask) | (wr_ofs_q & ~i_mask);
    assign o_rd_addr = (i_base & i_mask) | (rd_ofs_q & ~i_mask);
    assign o_wr_word = {i_tlast, i_tdata};              // last flag rides on top

    // no accept and no read in the clear cycle, window is being reset
    assign o_tready  = ready_q && !i_clear;
    assign o_wr_en   = i_tvalid && o_tready;            // write in acceptance cycle
    assign o_rd_en   = (fill_q != '0) && i_room && !i_clear;

    assign o_fill    = dram_fifo_pkg::set_data_t'(fill_q);

    // --------------------------------------------------
    // fill count
    // --------------------------------------------------
    always_comb begin
        fill_d = fill_q;
        if (i_clear) begin
            fill_d = '0;
        end else begin
            case ({o_wr_en, o_rd_en})
                2'b10:   fill_d = fill_q + count_t'(1); // write only
                2'b01:   fill_d = fill_q - count_t'(1); // read only
                default: fill_d = fill_q;               // none or both
            endcase
        end
    end

    always_ff @(posedge ddr3_axi_clk) begin
        if (i_rst) begin
            wr_ofs_q <= '0;
            rd_ofs_q <= '0;
            fill_q   <= '0;
            ready_q  <= 1'b0;                           // rises the cycle after reset
        end else begin
            if (i_clear) begin
                wr_ofs_q <= '0;
                rd_ofs_q <= '0;
            end else begin
                if (o_wr_en) begin
                    wr_ofs_q <= step_ofs(wr_ofs_q, ofs_last);
                end
                if (o_rd_en) begin
                    rd_ofs_q <= step_ofs(rd_ofs_q, ofs_last);
                end
            end
            fill_q  <= fill_d;
            ready_q <= fill_d < win_size;               // same as fill_q < size next cycle
        end
    end

endmodule

// ==== hw/fifo_word_ram.sv ====
// dual-port word memory, one write port and one registered read port
// forced bit errors are XORed into the data bits on write

`timescale 1ns/1ps

module fifo_word_ram #(
    parameter int ADDR_W = 10
) (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_wr_en,
    input  logic [ADDR_W-1:0]         i_wr_addr,
    input  dram_fifo_pkg::mem_word_t  i_wr_word,
    input  dram_fifo_pkg::tdata_t     i_bit_err,
    input  logic                      i_rd_en,
    input  logic [ADDR_W-1:0]         i_rd_addr,
    output dram_fifo_pkg::mem_word_t  o_rd_word
);

    localparam int DATA_W = dram_fifo_pkg::DATA_W;

    dram_fifo_pkg::mem_word_t mem [2**ADDR_W];          // storage, no reset
    dram_fifo_pkg::mem_word_t wr_word_err;              // word after error injection

    // last flag passes untouched
    assign wr_word_err = {i_wr_word[DATA_W], i_wr_word[DATA_W-1:0] ^ i_bit_err};

    // --------------------------------------------------
    // write and read ports
    // --------------------------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= wr_word_err;
        end
    end

    always_ff @(posedge ddr3_axi_clk) begin
        if (i_rd_en) begin
            o_rd_word <= mem[i_rd_addr];                // one cycle read latency
        end
    end

endmodule

// ==== hw/fifo_read_out.sv ====
// two-entry output buffer between memory read data and the output stream
// tracks reads in flight so memory never returns more than it can hold

`timescale 1ns/1ps

module fifo_read_out (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_rst,
    input  logic                      i_clear,
    input  logic                      i_rd_en,
    input  dram_fifo_pkg::mem_word_t  i_rd_word,
    output logic                      o_room,
    output dram_fifo_pkg::tdata_t     o_tdata,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_tready
);

    localparam int DATA_W = dram_fifo_pkg::DATA_W;

    dram_fifo_pkg::out_state_t state_q;                 // words held
    logic                      rd_pend_q;               // read data arrives this cycle
    dram_fifo_pkg::mem_word_t  buf0_q;                  // oldest word, on the stream
    dram_fifo_pkg::mem_word_t  buf1_q;                  // second word
    logic                      cap;
    logic                      pop;

    assign cap      = rd_pend_q;
    assign pop      = o_tvalid && i_tready;
    assign o_tvalid = (state_q != dram_fifo_pkg::EMPTY);
    assign o_tdata  = buf0_q[DATA_W-1:0];
    assign o_tlast  = buf0_q[DATA_W];

    // held plus in flight below two
    assign o_room = (state_q == dram_fifo_pkg::EMPTY) ||
                    ((state_q == dram_fifo_pkg::ONE) && !rd_pend_q);

    // --------------------------------------------------
    // control state
    // --------------------------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_rst || i_clear) begin
            state_q   <= dram_fifo_pkg::EMPTY;
            rd_pend_q <= 1'b0;                          // clear drops a read in flight
        end else begin
            rd_pend_q <= i_rd_en;
            case (state_q)
                dram_fifo_pkg::EMPTY: if (cap) state_q <= dram_fifo_pkg::ONE;
                dram_fifo_pkg::ONE: begin
                    if (cap && !pop) state_q <= dram_fifo_pkg::TWO;
                    else if (!cap && pop) state_q <= dram_fifo_pkg::EMPTY;
                end
                dram_fifo_pkg::TWO: if (pop && !cap) state_q <= dram_fifo_pkg::ONE;
                default: state_q <= dram_fifo_pkg::EMPTY;
            endcase
        end
    end

    // --------------------------------------------------
    // payload, shifts toward buf0 on pop
    // --------------------------------------------------
    always_ff @(posedge ddr3_axi_clk) begin
        case (state_q)
            dram_fifo_pkg::EMPTY: if (cap) buf0_q <= i_rd_word;
            dram_fifo_pkg::ONE: begin
                if (cap && pop) buf0_q <= i_rd_word;    // replace the word leaving
                else if (cap) buf1_q <= i_rd_word;
            end
            dram_fifo_pkg::TWO: begin
                if (pop) buf0_q <= buf1_q;
                if (cap) buf1_q <= i_rd_word;
            end
            default: buf0_q <= buf0_q;
        endcase
    end

endmodule

// ==== hw/dram_fifo_top.sv ====
// stream FIFO top level
// settings regs and pointer control feed a dual-port word memory,
// an output buffer drains it onto the output stream

`timescale 1ns/1ps

module dram_fifo_top #(
    parameter int                ADDR_W       = 10,                     // 1024 words
    parameter int                SR_BASE      = 0,
    parameter logic [ADDR_W-1:0] DEFAULT_BASE = '0,
    parameter logic [ADDR_W-1:0] DEFAULT_MASK = {ADDR_W{1'b1}} << 8     // 256 word window
) (
    input  logic                      ddr3_axi_clk,
    input  logic                      i_rst,
    // input stream
    input  dram_fifo_pkg::tdata_t     i_tdata,
    input  logic                      i_tlast,
    input  logic                      i_tvalid,
    output logic                      o_i_tready,
    // output stream
    output dram_fifo_pkg::tdata_t     o_tdata,
    output logic                      o_tlast,
    output logic                      o_tvalid,
    input  logic                      i_o_tready,
    // settings bus
    input  logic                      i_set_stb,
    input  dram_fifo_pkg::set_addr_t  i_set_addr,
    input  dram_fifo_pkg::set_data_t  i_set_data,
    output dram_fifo_pkg::set_data_t  o_rb_data,
    // error injection
    input  dram_fifo_pkg::tdata_t     i_forced_bit_err
);

    logic [ADDR_W-1:0]         win_base;        // window base from settings
    logic [ADDR_W-1:0]         win_mask;        // window mask from settings
    logic                      fifo_clear;      // one cycle, on any reg write
    logic                      out_room;        // output buffer can take a read
    logic                      mem_wr_en;
    logic [ADDR_W-1:0]         mem_wr_addr;
    dram_fifo_pkg::mem_word_t  mem_wr_word;
    logic                      mem_rd_en;
    logic [ADDR_W-1:0]         mem_rd_addr;
    dram_fifo_pkg::mem_word_t  mem_rd_word;     // valid one cycle after mem_rd_en

    // --------------------------------------------------
    // settings and FIFO control
    // --------------------------------------------------
    fifo_settings_regs #(
        .ADDR_W       (ADDR_W),
        .SR_BASE      (SR_BASE),
        .DEFAULT_BASE (DEFAULT_BASE),
        .DEFAULT_MASK (DEFAULT_MASK)
    ) u_settings (
        .ddr3_axi_clk (ddr3_axi_clk),
        .i_rst        (i_rst),
        .i_set_stb    (i_set_stb),
        .i_set_addr   (i_set_addr),
        .i_set_data   (i_set_data),
        .o_base       (win_base),
        .o_mask       (win_mask),
        .o_clear      (fifo_clear)
    );

    fifo_ptr_ctrl #(
        .ADDR_W       (ADDR_W)
    ) u_ptr_ctrl (
        .ddr3_axi_clk (ddr3_axi_clk),
        .i_rst        (i_rst),
        .i_clear      (fifo_clear),
        .i_base       (win_base),
        .i_mask       (win_mask),
        .i_tdata      (i_tdata),
        .i_tlast      (i_tlast),
        .i_tvalid     (i_tvalid),
        .o_tready     (o_i_tready),
        .i_room       (out_room),
        .o_wr_en      (mem_wr_en),
        .o_wr_addr    (mem_wr_addr),
        .o_wr_word    (mem_wr_word),
        .o_rd_en      (mem_rd_en),
        .o_rd_addr    (mem_rd_addr),
        .o_fill       (o_rb_data)       // readback is the memory fill count
    );

    // --------------------------------------------------
    // memory and stream out
    // --------------------------------------------------
    fifo_word_ram #(
        .ADDR_W       (ADDR_W)
    ) u_ram (
        .ddr3_axi_clk (ddr3_axi_clk),
        .i_wr_en      (mem_wr_en),
        .i_wr_addr    (mem_wr_addr),
        .i_wr_word    (mem_wr_word),
        .i_bit_err    (i_forced_bit_err),
        .i_rd_en      (mem_rd_en),
        .i_rd_addr    (mem_rd_addr),
        .o_rd_word    (mem_rd_word)
    );

    fifo_read_out u_read_out (
        .ddr3_axi_clk (ddr3_axi_clk),
        .i_rst        (i_rst),
        .i_clear      (fifo_clear),
        .i_rd_en      (mem_rd_en),
        .i_rd_word    (mem_rd_word),
        .o_room       (out_room),
        .o_tdata      (o_tdata),
        .o_tlast      (o_tlast),
        .o_tvalid     (o_tvalid),
        .i_tready     (i_o_tready)
    );

endmodule

// ==== verification/dram_fifo_sva.sv ====
// assertions on the FIFO pointer control
// fill bound, write and read legality, input ready after reset

`timescale 1ns/1ps

module dram_fifo_sva #(
    parameter int ADDR_W = 10
) (
    input logic                      ddr3_axi_clk,
    input logic                      i_rst,
    input logic                      i_clear,
    input logic [ADDR_W-1:0]         i_mask,
    input logic                      o_tready,
    input logic                      o_wr_en,
    input logic                      o_rd_en,
    input dram_fifo_pkg::set_data_t  o_fill
);

    logic [ADDR_W:0] win_size;                          // inverted mask plus one
    logic [ADDR_W:0] held;                              // writes minus reads since clear

    assign win_size = {1'b0, ~i_mask} + (ADDR_W+1)'(1);

    // own count of stored words, apart from the fill register
    always_ff @(posedge ddr3_axi_clk) begin
        if (i_rst || i_clear) begin
            held <= '0;
        end else if (o_wr_en && !o_rd_en) begin
            held <= held + (ADDR_W+1)'(1);
        end else if (o_rd_en && !o_wr_en) begin
            held <= held - (ADDR_W+1)'(1);
        end
    end

    // clear cycle skipped, the new mask is already in place there
    a_fill_bound: assert property (@(posedge ddr3_axi_clk) disable iff (i_rst || i_clear)
        o_fill <= dram_fifo_pkg::set_data_t'(win_size))
        else $error("fill count above window size");

    // input ready low means the window is full
    a_no_wr_full: assert property (@(posedge ddr3_axi_clk) disable iff (i_rst || i_clear)
        o_wr_en |-> (held < win_size))
        else $error("memory write with the window full");

    a_no_rd_empty: assert property (@(posedge ddr3_axi_clk) disable iff (i_rst)
        (held == '0) |-> !o_rd_en)
        else $error("memory read with no word stored");

    a_ready_after_rst: assert property (@(posedge ddr3_axi_clk)
        $fell(i_rst) |=> o_tready)
        else $error("input ready low one cycle after reset");

endmodule

bind fifo_ptr_ctrl dram_fifo_sva #(.ADDR_W(ADDR_W)) u_sva (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_rst        (i_rst),
    .i_clear      (i_clear),
    .i_mask       (i_mask),
    .o_tready     (o_tready),
    .o_wr_en      (o_wr_en),
    .o_rd_en      (o_rd_en),
    .o_fill       (o_fill)
);

// ==== verification/tb_dram_fifo.sv ====
// testbench for the stream FIFO
// random streams checked against a queue model, plus capacity, window and clear tests

`timescale 1ns/1ps

module tb_dram_fifo;

    localparam int WIN_DEFAULT = 256;                   // mask 0x300 on 10 address bits
    localparam int WIN_SMALL   = 16;                    // mask 0x3f0
    localparam int N_ORDER     = 400;
    localparam int N_ERR       = 200;
    localparam int N_WIN       = 100;
    localparam int N_HELD      = 10;
    localparam int N_AFTER     = 50;
    localparam int TOTAL_WORDS = N_ORDER + N_ERR + (WIN_DEFAULT + 2) + (WIN_SMALL + 2)
                               + N_WIN + N_HELD + N_AFTER;
    localparam int WATCHDOG_NS = TOTAL_WORDS * 20 * 20 + 20000;  // 20 cycles per word

    logic                      ddr3_axi_clk;
    logic                      i_rst;
    dram_fifo_pkg::tdata_t     i_tdata;
    logic                      i_tlast;
    logic                      i_tvalid;
    logic                      o_i_tready;
    dram_fifo_pkg::tdata_t     o_tdata;
    logic                      o_tlast;
    logic                      o_tvalid;
    logic                      i_o_tready;
    logic                      i_set_stb;
    dram_fifo_pkg::set_addr_t  i_set_addr;
    dram_fifo_pkg::set_data_t  i_set_data;
    dram_fifo_pkg::set_data_t  o_rb_data;
    dram_fifo_pkg::tdata_t     i_forced_bit_err;

    dram_fifo_pkg::mem_word_t  model_q[$];             // expected words, oldest first
    dram_fifo_pkg::mem_word_t  exp_w;
    int seed     = 16;
    int in_cnt   = 0;                                   // input handshakes
    int out_cnt  = 0;                                   // output handshakes
    int err_cnt  = 0;
    int test_cnt = 0;
    int out_base = 0;                                   // counts at start of current test
    int err_base = 0;

    dram_fifo_top DUT (.*);

    always #10 ddr3_axi_clk = ~ddr3_axi_clk;            // 20 ns period

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_data(input string name, input dram_fifo_pkg::tdata_t exp,
                              input dram_fifo_pkg::tdata_t got);
        if (got !== exp) begin
            $display("error %s expected 0x%h got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_last(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("error %s expected 0x%h got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_rb(input string name, input dram_fifo_pkg::set_data_t exp,
                            input dram_fifo_pkg::set_data_t got);
        if (got !== exp) begin
            $display("error %s expected 0x%h got 0x%h", name, exp, got);
            err_cnt++;
        end
    endtask

    // handshakes sampled mid cycle, where both streams are stable
    always @(negedge ddr3_axi_clk) begin
        if (!i_rst && i_tvalid && o_i_tready) begin
            model_q.push_back({i_tlast, i_tdata ^ i_forced_bit_err});  // vector at write time
            in_cnt++;
        end
        if (!i_rst && o_tvalid && i_o_tready) begin
            if (model_q.size() == 0) begin
                $display("an output word appeared while no word was expected");
                err_cnt++;
            end else begin
                exp_w = model_q.pop_front();
                check_data("o_tdata", exp_w[dram_fifo_pkg::DATA_W-1:0], o_tdata);
                check_last("o_tlast", exp_w[dram_fifo_pkg::DATA_W], o_tlast);
            end
            out_cnt++;
        end
    end

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------
    function automatic logic chance(input int pct);
        int r;
        r = $random(seed);
        return ((r & 32'h7fffffff) % 100) < pct;
    endfunction

    task automatic present_word();
        logic [31:0] r;
        r = $random(seed);
        i_tdata  <= {$random(seed), $random(seed)};
        i_tlast  <= r[0];
        i_tvalid <= 1'b1;
    endtask

    // n words with random valid and ready duty, word held until taken
    task automatic stream_words(input int n, input int vpct, input int rpct);
        int start;
        int sent;
        start = in_cnt;
        sent  = 0;
        while (in_cnt - start < n) begin
            @(posedge ddr3_axi_clk);
            i_o_tready <= chance(rpct);
            if (in_cnt - start == sent) begin           // nothing pending
                if (sent < n && chance(vpct)) begin
                    present_word();
                    sent++;
                end else begin
                    i_tvalid <= 1'b0;
                end
            end
        end
    endtask

    task automatic drain(input int rpct);
        while (model_q.size() != 0) begin
            @(posedge ddr3_axi_clk);
            i_o_tready <= chance(rpct);
        end
    endtask

    // output stalled, push until input ready stays low
    task automatic fill_stalled(input int win);
        int start;
        int sent;
        int idle;
        start = in_cnt;
        sent  = 0;
        idle  = 0;
        while (idle < 20) begin
            @(posedge ddr3_axi_clk);
            i_o_tready <= 1'b0;
            if (in_cnt - start == sent) begin
                present_word();
                sent++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        i_tvalid <= 1'b0;
        if (in_cnt - start != win + 2) begin           // window plus two buffered
            $display("capacity wrong, %0d words accepted with the output stalled, %0d expected",
                     in_cnt - start, win + 2);
            err_cnt++;
        end
        @(negedge ddr3_axi_clk);
        check_rb("o_rb_data", dram_fifo_pkg::set_data_t'(win), o_rb_data);
    endtask

    task automatic write_reg(input dram_fifo_pkg::set_addr_t addr,
                             input dram_fifo_pkg::set_data_t data);
        @(posedge ddr3_axi_clk);
        i_set_stb  <= 1'b1;
        i_set_addr <= addr;
        i_set_data <= data;
        @(posedge ddr3_axi_clk);
        i_set_stb  <= 1'b0;
    endtask

    task automatic check_idle();
        repeat (3) @(negedge ddr3_axi_clk);
        check_rb("o_rb_data", '0, o_rb_data);
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("test %0d %s done, %0d words out, %0d errors",
                 test_cnt, name, out_cnt - out_base, err_cnt - err_base);
        out_base = out_cnt;
        err_base = err_cnt;
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        ddr3_axi_clk     = 1'b0;
        i_rst            = 1'b1;
        i_tdata          = '0;
        i_tlast          = 1'b0;
        i_tvalid         = 1'b0;
        i_o_tready       = 1'b0;
        i_set_stb        = 1'b0;
        i_set_addr       = '0;
        i_set_data       = '0;
        i_forced_bit_err = '0;
        repeat (2) @(posedge ddr3_axi_clk);
        i_rst <= 1'b0;

        stream_words(N_ORDER, 70, 60);
        drain(60);
        check_idle();
        report_test("order and integrity");

        @(posedge ddr3_axi_clk);
        i_forced_bit_err <= {$random(seed), $random(seed)};
        stream_words(N_ERR, 80, 70);
        drain(70);
        @(posedge ddr3_axi_clk);
        i_forced_bit_err <= '0;
        check_idle();
        report_test("bit error injection");

        fill_stalled(WIN_DEFAULT);
        drain(100);
        check_idle();
        report_test("capacity and readback");

        write_reg(dram_fifo_pkg::REG_BASE_OFS, 32'h0000_0120);
        write_reg(dram_fifo_pkg::REG_MASK_OFS, 32'h0000_03f0);     // 16 word window
        repeat (3) @(posedge ddr3_axi_clk);
        fill_stalled(WIN_SMALL);
        drain(100);
        stream_words(N_WIN, 70, 50);                    // wraps the small window many times
        drain(50);
        check_idle();
        report_test("window reconfiguration");

        stream_words(N_HELD, 100, 0);                   // held in memory and buffer
        repeat (4) @(posedge ddr3_axi_clk);
        write_reg(dram_fifo_pkg::REG_BASE_OFS, 32'h0000_0040);
        repeat (3) @(negedge ddr3_axi_clk);
        if (o_tvalid !== 1'b0) begin
            $display("output still valid after the clear by a register write");
            err_cnt++;
        end
        check_rb("o_rb_data", '0, o_rb_data);
        @(posedge ddr3_axi_clk);
        model_q.delete();                               // held words are dropped
        stream_words(N_AFTER, 80, 80);
        drain(80);
        check_idle();
        report_test("clear on register write");

        $display("%0d tests run, %0d words checked, %0d errors", test_cnt, out_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== build.f ====
hw/dram_fifo_pkg.sv
hw/fifo_settings_regs.sv
hw/fifo_ptr_ctrl.sv
hw/fifo_word_ram.sv
hw/fifo_read_out.sv
hw/dram_fifo_top.sv
verification/dram_fifo_sva.sv
verification/tb_dram_fifo.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the stream FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_dram_fifo -Mdir obj_dir -f build.f

# the log decides the result, the pipe status is that of tee
./obj_dir/Vtb_dram_fifo 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail"
exit 1
